// ==== vlog.f ====
+incdir+design
design/adma_pkg.sv
design/burst_if.sv
design/adma_descriptor_seq.sv
design/axi_burst_reader.sv
design/axi_burst_writer.sv
design/sd_adma_top.sv
tb/sd_adma_tb.sv

// ==== Bender.yml ====
package:
  name: sd_adma

sources:
  - include_dirs:
      - design
    files:
      - design/adma_pkg.sv
      - design/burst_if.sv
      - design/adma_descriptor_seq.sv
      - design/axi_burst_reader.sv
      - design/axi_burst_writer.sv
      - design/sd_adma_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - tb/sd_adma_tb.sv

// ==== tb/sd_adma_tb.sv ====
`default_nettype none
`include "adma_consts.svh"

module sd_adma_tb;

  localparam int CLK_PERIOD = 40;
  localparam int MEM_WORDS  = 1024;
  // Cycle budget of reset, idle check, mem-to-card, card-to-mem, link, invalid and rerun
  localparam int TEST_CYCLES     = 8 + 10 + 400 + 300 + 300 + 80 + 250;
  localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES;

  logic        clock;
  logic        reset;
  logic        dma_enable, cmd_done, data_present, card_to_mem;
  logic        xfer_done, irq_clear;
  logic [31:0] desc_base;
  logic [1:0]  irq;
  logic        fifo_clear, fifo_push, fifo_pop, card_word_we;
  logic [31:0] fifo_wr_data, fifo_rd_data;
  logic [31:0] araddr, rdata, awaddr, wdata;
  logic [7:0]  arlen, awlen;
  logic        arvalid, arready, rvalid, rready, rlast;
  logic        awvalid, awready, wvalid, wready, wlast, bvalid, bready;

  // Memory and card FIFO models
  logic [31:0] mem [0:MEM_WORDS-1];
  logic [31:0] card_q [$];
  logic [31:0] card_words [0:15];
  logic [31:0] rd_addr, wr_addr, ar_addr_s, aw_addr_s, w_data_s;
  logic [7:0]  ar_len_s;
  logic [7:0]  aw_len_s;
  logic [7:0]  aw_len_seen;
  logic        ar_hs, r_hs, aw_hs, w_hs, b_hs, w_last_s;
  int          rd_left = 0;
  int          w_left = 0;
  int          push_count = 0;
  int          aw_cycles = 0;
  int          ar_count = 0;
  int          b_count = 0;
  int          wlast_bad = 0;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  integer      seed = 56326;

  sd_adma_top dut_i (
    .clock (clock), .reset (reset),
    .dma_enable (dma_enable), .cmd_done (cmd_done), .data_present (data_present),
    .card_to_mem (card_to_mem), .xfer_done (xfer_done), .irq_clear (irq_clear),
    .desc_base (desc_base), .irq (irq),
    .fifo_clear (fifo_clear), .fifo_push (fifo_push), .fifo_wr_data (fifo_wr_data),
    .fifo_pop (fifo_pop), .fifo_rd_data (fifo_rd_data), .card_word_we (card_word_we),
    .araddr (araddr), .arlen (arlen), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rvalid (rvalid), .rready (rready), .rlast (rlast),
    .awaddr (awaddr), .awlen (awlen), .awvalid (awvalid), .awready (awready),
    .wdata (wdata), .wvalid (wvalid), .wready (wready), .wlast (wlast),
    .bvalid (bvalid), .bready (bready)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the run did not finish in time");
    $display("TEST FAIL");
    $finish;
  end

  function automatic int word_index(input logic [31:0] addr);
    return int'((addr >> 2) & (MEM_WORDS - 1));
  endfunction

  // Fill value unique for every word of the memory
  function automatic logic [31:0] mem_pattern(input int idx);
    return 32'hC3A50000 ^ (32'(idx) * 32'h00010003);
  endfunction

  function automatic logic [31:0] make_attr(input logic [1:0] act, input logic last,
                                            input logic [15:0] bytes);
    logic [31:0] attr;
    attr = 32'(bytes) << `ADMA_DESC_LEN_LSB;
    attr = attr | (32'(act) << `ADMA_DESC_ACT_LSB);
    attr = attr | (32'(last) << `ADMA_DESC_END);
    attr = attr | (32'h1 << `ADMA_DESC_VALID);
    return attr;
  endfunction

  ////////////////////
  // AXI slave and card FIFO model sampling at the edge and driving 2 units later
  always begin
    @(posedge clock);
    ar_hs     = arvalid & arready;
    r_hs      = rvalid & rready;
    aw_hs     = awvalid & awready;
    w_hs      = wvalid & wready;
    b_hs      = bvalid & bready;
    ar_addr_s = araddr;
    ar_len_s  = arlen;
    aw_addr_s = awaddr;
    aw_len_s  = awlen;
    w_data_s  = wdata;
    w_last_s  = wlast;
    if (awvalid === 1'b1) begin
      aw_cycles++;
    end
    if (fifo_clear === 1'b1) begin
      card_q.delete();
    end
    if (fifo_push === 1'b1) begin
      card_q.push_back(fifo_wr_data);
      push_count++;
    end
    if (fifo_pop === 1'b1 && card_q.size() > 0) begin
      card_q.delete(0);
    end
    #2;
    // Read channel with one burst in flight
    if (r_hs) begin
      rd_addr = rd_addr + 32'd4;
      rd_left--;
    end
    if (ar_hs) begin
      rd_addr = ar_addr_s;
      rd_left = int'(ar_len_s) + 1;
      ar_count++;
    end
    rvalid = (rd_left != 0);
    rlast  = (rd_left == 1);
    rdata  = (rd_left != 0) ? mem[word_index(rd_addr)] : 32'h0;
    // Write channel
    if (b_hs) begin
      bvalid = 1'b0;
      b_count++;
    end
    if (aw_hs) begin
      wr_addr     = aw_addr_s;
      aw_len_seen = aw_len_s;
      w_left      = int'(aw_len_s) + 1;
    end
    if (w_hs) begin
      mem[word_index(wr_addr)] = w_data_s;
      wr_addr = wr_addr + 32'd4;
      // wlast belongs on the beat that ends the AW length
      if (w_last_s !== (w_left == 1)) begin
        wlast_bad++;
      end
      w_left--;
      if (w_last_s) begin
        bvalid = 1'b1;
      end
    end
    arready = ($random(seed) & 3) != 0;
    awready = ($random(seed) & 3) != 0;
    wready  = ($random(seed) & 3) != 0;
    fifo_rd_data = (card_q.size() > 0) ? card_q[0] : 32'h0;
  end

  task automatic report_err(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    $display("ERR %s: expected %h actual %h", name, exp, act);
    errors++;
  endtask

  task automatic report_fail(input string name, input string what);
    $display("%s: %s", name, what);
    errors++;
  endtask

  task automatic write_desc(input logic [31:0] addr, input logic [31:0] attr,
                            input logic [31:0] target);
    mem[word_index(addr)]     = attr;
    mem[word_index(addr + 4)] = target;
  endtask

  task automatic start_dma(input logic [31:0] base, input logic c2m);
    @(posedge clock);
    #2;
    desc_base    = base;
    card_to_mem  = c2m;
    push_count   = 0;
    aw_cycles    = 0;
    ar_count     = 0;
    b_count      = 0;
    wlast_bad    = 0;
    aw_len_seen  = 8'h00;
    dma_enable   = 1'b1;
    cmd_done     = 1'b1;
    data_present = 1'b1;
    @(posedge clock);
    #2;
    dma_enable   = 1'b0;
    cmd_done     = 1'b0;
    data_present = 1'b0;
  endtask

  task automatic pulse_xfer_done();
    @(posedge clock);
    #2;
    xfer_done = 1'b1;
    @(posedge clock);
    #2;
    xfer_done = 1'b0;
  endtask

  task automatic write_card_word(input logic [31:0] word);
    @(posedge clock);
    card_q.push_back(word);
    #2;
    card_word_we = 1'b1;
    @(posedge clock);
    #2;
    card_word_we = 1'b0;
  endtask

  task automatic wait_irq(input string name, input int limit);
    int n;
    n = 0;
    while (irq === 2'b00 && n < limit) begin
      @(posedge clock);
      n++;
    end
    if (irq === 2'b00) begin
      report_fail(name, "irq did not rise before the timeout");
    end
  endtask

  task automatic wait_pushes(input string name, input int count, input int limit);
    int n;
    n = 0;
    while (push_count < count && n < limit) begin
      @(posedge clock);
      n++;
    end
    if (push_count < count) begin
      report_fail(name, "too few FIFO pushes before the timeout");
    end
  endtask

  task automatic wait_fifo_clear(input string name, input int limit);
    int  n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < limit) begin
      @(posedge clock);
      seen = (fifo_clear === 1'b1);
      n++;
    end
    if (!seen) begin
      report_fail(name, "fifo_clear never pulsed");
    end
  endtask

  task automatic check_fifo(input string name, input logic [31:0] base, input int n);
    if (card_q.size() != n) begin
      report_err(name, 32'(n), 32'(card_q.size()));
    end
    for (int i = 0; i < n && i < card_q.size(); i++) begin
      if (card_q[i] !== mem_pattern(word_index(base + 32'(4 * i)))) begin
        report_err(name, mem_pattern(word_index(base + 32'(4 * i))), card_q[i]);
      end
    end
  endtask

  // Prints the result line and leaves irq cleared for the next test
  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - err_before);
    end
    @(posedge clock);
    #2;
    irq_clear   = 1'b1;
    card_to_mem = 1'b0;
    @(posedge clock);
    #2;
    irq_clear = 1'b0;
  endtask

  ////////////////////
  // Directed tests
  task automatic check_idle_outputs();
    int err0;
    err0 = errors;
    @(posedge clock);
    #2;
    if ({irq, arvalid, awvalid, wvalid, fifo_push, fifo_pop} !== 7'b0) begin
      report_err("idle_outputs", 32'h0, {irq, arvalid, awvalid, wvalid, fifo_push, fifo_pop});
    end
    finish_test("idle_outputs", err0);
  endtask

  task automatic move_mem_to_card();
    int err0;
    err0 = errors;
    write_desc(32'h100, make_attr(adma_pkg::TRAN, 1'b1, 16'd128), 32'h400);
    start_dma(32'h100, 1'b0);
    wait_pushes("mem_to_card", 32, 600);
    repeat (10) @(posedge clock);
    // END descriptor must hold off until the card side reports done
    if (irq !== 2'b00) begin
      report_err("mem_to_card", 32'h0, 32'(irq));
    end
    pulse_xfer_done();
    wait_irq("mem_to_card", 100);
    if (irq !== 2'b01) begin
      report_err("mem_to_card", 32'h1, 32'(irq));
    end
    check_fifo("mem_to_card", 32'h400, 32);
    // One descriptor fetch and two 16-word data bursts
    if (ar_count != 3) begin
      report_err("mem_to_card", 32'h3, 32'(ar_count));
    end
    finish_test("mem_to_card", err0);
  endtask

  task automatic move_card_to_mem();
    int err0;
    err0 = errors;
    write_desc(32'h140, make_attr(adma_pkg::TRAN, 1'b1, 16'd64), 32'h600);
    start_dma(32'h140, 1'b1);
    wait_fifo_clear("card_to_mem", 100);
    for (int i = 0; i < 16; i++) begin
      card_words[i] = $random(seed);
    end
    for (int i = 0; i < 15; i++) begin
      write_card_word(card_words[i]);
    end
    repeat (8) @(posedge clock);
    if (aw_cycles != 0) begin
      report_fail("card_to_mem", "awvalid rose before the 16th card word");
    end
    write_card_word(card_words[15]);
    pulse_xfer_done();
    wait_irq("card_to_mem", 400);
    if (irq !== 2'b01) begin
      report_err("card_to_mem", 32'h1, 32'(irq));
    end
    for (int i = 0; i < 16; i++) begin
      if (mem[word_index(32'h600 + 32'(4 * i))] !== card_words[i]) begin
        report_err("card_to_mem", card_words[i], mem[word_index(32'h600 + 32'(4 * i))]);
      end
    end
    // A 16-word burst has AW length 15
    if (aw_len_seen !== 8'(`ADMA_BURST_WORDS - 1)) begin
      report_err("card_to_mem", 32'(`ADMA_BURST_WORDS - 1), 32'(aw_len_seen));
    end
    if (wlast_bad != 0) begin
      report_fail("card_to_mem", "wlast did not mark the last beat of the burst");
    end
    if (b_count != 1) begin
      report_err("card_to_mem", 32'h1, 32'(b_count));
    end
    finish_test("card_to_mem", err0);
  endtask

  task automatic follow_link_chain();
    int err0;
    err0 = errors;
    write_desc(32'h200, make_attr(adma_pkg::LINK, 1'b0, 16'd0), 32'h300);
    write_desc(32'h300, make_attr(adma_pkg::TRAN, 1'b1, 16'd64), 32'h700);
    start_dma(32'h200, 1'b0);
    wait_pushes("link_chain", 16, 400);
    pulse_xfer_done();
    wait_irq("link_chain", 100);
    if (irq !== 2'b01) begin
      report_err("link_chain", 32'h1, 32'(irq));
    end
    check_fifo("link_chain", 32'h700, 16);
    finish_test("link_chain", err0);
  endtask

  task automatic reject_invalid_desc();
    int err0;
    err0 = errors;
    write_desc(32'h180, 32'h0, 32'h0);
    start_dma(32'h180, 1'b0);
    wait_irq("invalid_desc", 100);
    if (irq !== 2'b10) begin
      report_err("invalid_desc", 32'h2, 32'(irq));
    end
    if (push_count != 0) begin
      report_fail("invalid_desc", "fifo_push pulsed for an invalid descriptor");
    end
    if (aw_cycles != 0) begin
      report_fail("invalid_desc", "an AW request appeared for an invalid descriptor");
    end
    finish_test("invalid_desc", err0);
  endtask

  task automatic clear_then_rerun();
    int err0;
    err0 = errors;
    if (irq !== 2'b00) begin
      report_err("clear_rerun", 32'h0, 32'(irq));
    end
    write_desc(32'h1C0, make_attr(adma_pkg::TRAN, 1'b1, 16'd64), 32'h800);
    start_dma(32'h1C0, 1'b0);
    wait_pushes("clear_rerun", 16, 400);
    pulse_xfer_done();
    wait_irq("clear_rerun", 100);
    if (irq !== 2'b01) begin
      report_err("clear_rerun", 32'h1, 32'(irq));
    end
    check_fifo("clear_rerun", 32'h800, 16);
    finish_test("clear_rerun", err0);
  endtask

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = mem_pattern(i);
    end
    reset        = 1'b0;
    dma_enable   = 1'b0;
    cmd_done     = 1'b0;
    data_present = 1'b0;
    card_to_mem  = 1'b0;
    xfer_done    = 1'b0;
    irq_clear    = 1'b0;
    desc_base    = 32'h0;
    card_word_we = 1'b0;
    fifo_rd_data = 32'h0;
    arready      = 1'b0;
    rvalid       = 1'b0;
    rdata        = 32'h0;
    rlast        = 1'b0;
    awready      = 1'b0;
    wready       = 1'b0;
    bvalid       = 1'b0;
    repeat (8) @(posedge clock);
    #2;
    reset = 1'b1;
    check_idle_outputs();
    move_mem_to_card();
    move_card_to_mem();
    follow_link_chain();
    reject_invalid_desc();
    clear_then_rerun();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/sd_adma_top.sv ====
`default_nettype none
`include "adma_consts.svh"

module sd_adma_top (
  input  logic                    clock,
  input  logic                    reset,
  // Host controller side
  input  logic                    dma_enable,
  input  logic                    cmd_done,
  input  logic                    data_present,
  input  logic                    card_to_mem,
  input  logic                    xfer_done,
  input  logic                    irq_clear,
  input  logic [`ADMA_ADDR_W-1:0] desc_base,
  output logic [1:0]              irq,
  // Card data FIFO
  output logic                    fifo_clear,
  output logic                    fifo_push,
  output logic [`ADMA_ADDR_W-1:0] fifo_wr_data,
  output logic                    fifo_pop,
  input  logic [`ADMA_ADDR_W-1:0] fifo_rd_data,
  input  logic                    card_word_we,
  // AXI read channels
  output logic [`ADMA_ADDR_W-1:0] araddr,
  output logic [7:0]              arlen,
  output logic                    arvalid,
  input  logic                    arready,
  input  logic [`ADMA_ADDR_W-1:0] rdata,
  input  logic                    rvalid,
  output logic                    rready,
  input  logic                    rlast,
  // AXI write channels
  output logic [`ADMA_ADDR_W-1:0] awaddr,
  output logic [7:0]              awlen,
  output logic                    awvalid,
  input  logic                    awready,
  output logic [`ADMA_ADDR_W-1:0] wdata,
  output logic                    wvalid,
  input  logic                    wready,
  output logic                    wlast,
  input  logic                    bvalid,
  output logic                    bready
);

  burst_if rd_bus ();
  burst_if wr_bus ();

  // Read data goes straight into the card FIFO
  assign fifo_wr_data = rdata;

  adma_descriptor_seq seq_i (
    .clock        (clock),
    .reset        (reset),
    .dma_enable   (dma_enable),
    .cmd_done     (cmd_done),
    .data_present (data_present),
    .card_to_mem  (card_to_mem),
    .xfer_done    (xfer_done),
    .irq_clear    (irq_clear),
    .desc_base    (desc_base),
    .irq          (irq),
    .fifo_clear   (fifo_clear),
    .rd           (rd_bus.requester),
    .wr           (wr_bus.requester)
  );

  axi_burst_reader reader_i (
    .clock     (clock),
    .reset     (reset),
    .req       (rd_bus.mover),
    .araddr    (araddr),
    .arlen     (arlen),
    .arvalid   (arvalid),
    .arready   (arready),
    .rvalid    (rvalid),
    .rlast     (rlast),
    .rdata     (rdata),
    .rready    (rready),
    .fifo_push (fifo_push)
  );

  axi_burst_writer writer_i (
    .clock        (clock),
    .reset        (reset),
    .req          (wr_bus.mover),
    .card_word_we (card_word_we),
    .fifo_data    (fifo_rd_data),
    .fifo_pop     (fifo_pop),
    .awaddr       (awaddr),
    .awlen        (awlen),
    .awvalid      (awvalid),
    .awready      (awready),
    .wdata        (wdata),
    .wvalid       (wvalid),
    .wlast        (wlast),
    .wready       (wready),
    .bvalid       (bvalid),
    .bready       (bready)
  );

endmodule

`default_nettype wire

// ==== design/axi_burst_writer.sv ====
`default_nettype none
`include "adma_consts.svh"

module axi_burst_writer (
  input  logic                    clock,
  input  logic                    reset,
  burst_if.mover                  req,
  input  logic                    card_word_we,
  input  logic [`ADMA_ADDR_W-1:0] fifo_data,
  output logic                    fifo_pop,
  output logic [`ADMA_ADDR_W-1:0] awaddr,
  output logic [7:0]              awlen,
  output logic                    awvalid,
  input  logic                    awready,
  output logic [`ADMA_ADDR_W-1:0] wdata,
  output logic                    wvalid,
  output logic                    wlast,
  input  logic                    wready,
  input  logic                    bvalid,
  output logic                    bready
);

  localparam int unsigned BEAT_W = $clog2(`ADMA_BURST_WORDS);

  adma_pkg::burst_state_t state;
  logic [`ADMA_LEN_W-1:0] total;
  logic [`ADMA_LEN_W-1:0] sent;
  logic [`ADMA_LEN_W-1:0] we_count;
  logic [BEAT_W-1:0]      beat_idx;
  logic                   we_s1;
  logic                   we_s2;
  logic                   we_fall;
  logic                   w_beat;

  assign we_fall  = we_s2 & ~we_s1;
  assign w_beat   = wvalid & wready;
  assign awlen    = 8'(`ADMA_BURST_WORDS - 1);
  assign wdata    = fifo_data;
  assign req.beat = w_beat;
  assign req.data = fifo_data;

  ////////////////////
  // Card word counter, falling edges of the write strobe
  always_ff @(posedge clock) begin
    if (!reset) begin
      we_s1    <= 1'b0;
      we_s2    <= 1'b0;
      we_count <= '0;
    end else begin
      we_s1 <= card_word_we;
      we_s2 <= we_s1;
      if ((state == adma_pkg::BS_IDLE) && req.start) begin
        we_count <= '0;
      end else if (we_fall) begin
        we_count <= we_count + 1'b1;
      end
    end
  end

  // Single cycle acknowledge of each response
  always_ff @(posedge clock) begin
    if (!reset) begin
      bready <= 1'b0;
    end else begin
      bready <= bvalid & ~bready;
    end
  end

  ////////////////////
  // Burst FSM
  always_ff @(posedge clock) begin
    if (!reset) begin
      state    <= adma_pkg::BS_IDLE;
      awvalid  <= 1'b0;
      wvalid   <= 1'b0;
      wlast    <= 1'b0;
      fifo_pop <= 1'b0;
      req.done <= 1'b0;
    end else begin
      req.done <= 1'b0;
      fifo_pop <= w_beat;   // head moves on during the wvalid gap
      case (state)
        adma_pkg::BS_IDLE: begin
          if (req.start) begin
            awaddr <= req.addr;
            total  <= req.words;
            sent   <= '0;
            state  <= adma_pkg::BS_WAIT;
          end
        end
        adma_pkg::BS_WAIT: begin
          // Only start a burst once a full burst sits in the FIFO
          if (we_count >= sent + `ADMA_LEN_W'(`ADMA_BURST_WORDS)) begin
            awvalid <= 1'b1;
            state   <= adma_pkg::BS_ADDR;
          end
        end
        adma_pkg::BS_ADDR: begin
          if (awready) begin
            awvalid  <= 1'b0;
            awaddr   <= awaddr + `ADMA_ADDR_W'(`ADMA_BURST_BYTES);
            wvalid   <= 1'b1;
            beat_idx <= '0;
            state    <= adma_pkg::BS_DATA;
          end
        end
        adma_pkg::BS_DATA: begin
          if (w_beat) begin
            wvalid   <= 1'b0;
            sent     <= sent + 1'b1;
            beat_idx <= beat_idx + 1'b1;
            if (wlast) begin
              wlast <= 1'b0;
              if (sent + 1'b1 == total) begin
                req.done <= 1'b1;
                state    <= adma_pkg::BS_IDLE;
              end else begin
                state <= adma_pkg::BS_WAIT;
              end
            end else if (beat_idx == BEAT_W'(`ADMA_BURST_WORDS - 2)) begin
              wlast <= 1'b1;
            end
          end else if (!wvalid) begin
            wvalid <= 1'b1;
          end
        end
        default: state <= adma_pkg::BS_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/axi_burst_reader.sv ====
`default_nettype none
`include "adma_consts.svh"

module axi_burst_reader (
  input  logic                    clock,
  input  logic                    reset,
  burst_if.mover                  req,
  output logic [`ADMA_ADDR_W-1:0] araddr,
  output logic [7:0]              arlen,
  output logic                    arvalid,
  input  logic                    arready,
  input  logic                    rvalid,
  input  logic                    rlast,
  input  logic [`ADMA_ADDR_W-1:0] rdata,
  output logic                    rready,
  output logic                    fifo_push
);

  adma_pkg::burst_state_t state;
  logic [`ADMA_LEN_W-1:0] words_left;
  logic                   to_desc;
  logic                   rready_en;
  logic                   beat;

  // At most one beat every second cycle
  assign rready    = rready_en & rvalid & (state == adma_pkg::BS_DATA);
  assign beat      = rready;
  assign fifo_push = beat & ~to_desc;
  assign arlen     = to_desc ? 8'(`ADMA_DESC_WORDS - 1) : 8'(`ADMA_BURST_WORDS - 1);
  assign req.beat  = beat;
  assign req.data  = rdata;

  always_ff @(posedge clock) begin
    if (!reset) begin
      rready_en <= 1'b0;
    end else begin
      rready_en <= ~beat;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state    <= adma_pkg::BS_IDLE;
      arvalid  <= 1'b0;
      to_desc  <= 1'b0;
      req.done <= 1'b0;
    end else begin
      req.done <= 1'b0;
      case (state)
        adma_pkg::BS_IDLE: begin
          if (req.start) begin
            araddr     <= req.addr;
            words_left <= req.words;
            to_desc    <= req.to_desc;
            arvalid    <= 1'b1;
            state      <= adma_pkg::BS_ADDR;
          end
        end
        adma_pkg::BS_ADDR: begin
          if (arready) begin
            arvalid <= 1'b0;
            state   <= adma_pkg::BS_DATA;
          end
        end
        adma_pkg::BS_DATA: begin
          if (beat) begin
            words_left <= words_left - 1'b1;
            if (rlast) begin
              if (words_left != `ADMA_LEN_W'(1)) begin
                araddr  <= araddr + `ADMA_ADDR_W'(`ADMA_BURST_BYTES);
                arvalid <= 1'b1;
                state   <= adma_pkg::BS_ADDR;
              end else begin
                req.done <= 1'b1;
                state    <= adma_pkg::BS_IDLE;
              end
            end
          end
        end
        default: state <= adma_pkg::BS_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/adma_descriptor_seq.sv ====
`default_nettype none
`include "adma_consts.svh"

module adma_descriptor_seq (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    dma_enable,
  input  logic                    cmd_done,
  input  logic                    data_present,
  input  logic                    card_to_mem,
  input  logic                    xfer_done,
  input  logic                    irq_clear,
  input  logic [`ADMA_ADDR_W-1:0] desc_base,
  output logic [1:0]              irq,
  output logic                    fifo_clear,
  burst_if.requester              rd,
  burst_if.requester              wr
);

  adma_pkg::adma_state_t     state;
  logic [`ADMA_ADDR_W-1:0]   desc_ptr;
  logic [2*`ADMA_ADDR_W-1:0] desc;
  logic [`ADMA_ADDR_W-1:0]   job_addr;
  logic [`ADMA_LEN_W-1:0]    job_words;
  logic                      job_to_desc;
  logic                      rd_start;
  logic                      wr_start;
  logic                      busy;
  logic                      xfer_seen;
  logic                      run_start;
  adma_pkg::desc_act_t       desc_act;
  logic [15:0]               desc_len;
  logic [`ADMA_ADDR_W-1:0]   desc_addr;
  logic [`ADMA_LEN_W-1:0]    desc_bytes;

  assign run_start = dma_enable & cmd_done & data_present;

  ////////////////////
  // Descriptor fields
  assign desc_act   = adma_pkg::desc_act_t'(desc[`ADMA_DESC_ACT_LSB +: 2]);
  assign desc_len   = desc[`ADMA_DESC_LEN_LSB +: 16];
  assign desc_addr  = desc[`ADMA_DESC_ADDR_LSB +: `ADMA_ADDR_W];
  // Zero length stands for 64 KiB
  assign desc_bytes = (desc_len == 16'h0000) ? `ADMA_LEN_W'(32'h10000) : `ADMA_LEN_W'(desc_len);

  // One job register set feeds both movers
  assign rd.start   = rd_start;
  assign rd.addr    = job_addr;
  assign rd.words   = job_words;
  assign rd.to_desc = job_to_desc;
  assign wr.start   = wr_start;
  assign wr.addr    = job_addr;
  assign wr.words   = job_words;
  assign wr.to_desc = 1'b0;

  ////////////////////
  // Sequencer FSM
  always_ff @(posedge clock) begin
    if (!reset) begin
      state      <= adma_pkg::STOP;
      rd_start   <= 1'b0;
      wr_start   <= 1'b0;
      fifo_clear <= 1'b0;
      busy       <= 1'b0;
      xfer_seen  <= 1'b0;
      irq        <= 2'b00;
    end else begin
      rd_start   <= 1'b0;
      wr_start   <= 1'b0;
      fifo_clear <= 1'b0;
      // Card side may finish before the DMA side does
      if (xfer_done) begin
        xfer_seen <= 1'b1;
      end
      case (state)
        adma_pkg::STOP: begin
          if (run_start) begin
            desc_ptr    <= desc_base;
            job_addr    <= desc_base;
            job_words   <= `ADMA_LEN_W'(`ADMA_DESC_WORDS);
            job_to_desc <= 1'b1;
            rd_start    <= 1'b1;
            xfer_seen   <= 1'b0;
            state       <= adma_pkg::FETCH;
          end
        end
        adma_pkg::FETCH: begin
          // Low word arrives first
          if (rd.beat) begin
            desc <= {rd.data, desc[2*`ADMA_ADDR_W-1:`ADMA_ADDR_W]};
          end
          if (rd.done) begin
            state <= adma_pkg::DECODE;
          end
        end
        adma_pkg::DECODE: begin
          if (!desc[`ADMA_DESC_VALID]) begin
            irq[1] <= 1'b1;
            state  <= adma_pkg::STOP;
          end else begin
            if (desc_act == adma_pkg::LINK) begin
              desc_ptr <= desc_addr;
            end else begin
              desc_ptr <= desc_ptr + `ADMA_ADDR_W'(`ADMA_DESC_STEP);
            end
            if (desc_act == adma_pkg::TRAN) begin
              job_addr    <= desc_addr;
              job_words   <= desc_bytes >> 2;
              job_to_desc <= 1'b0;
              rd_start    <= ~card_to_mem;
              wr_start    <= card_to_mem;
              fifo_clear  <= 1'b1;
              busy        <= 1'b1;
              xfer_seen   <= 1'b0;
            end
            state <= adma_pkg::XFER;
          end
        end
        adma_pkg::XFER: begin
          if (busy) begin
            if (rd.done | wr.done) begin
              busy <= 1'b0;
            end
          end else if (desc[`ADMA_DESC_END]) begin
            if (xfer_seen) begin
              irq[0] <= 1'b1;
              state  <= adma_pkg::STOP;
            end
          end else begin
            // Next line of the table
            job_addr    <= desc_ptr;
            job_words   <= `ADMA_LEN_W'(`ADMA_DESC_WORDS);
            job_to_desc <= 1'b1;
            rd_start    <= 1'b1;
            state       <= adma_pkg::FETCH;
          end
        end
        default: state <= adma_pkg::STOP;
      endcase
      if (irq_clear) begin
        irq <= 2'b00;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/burst_if.sv ====
`default_nettype none
`include "adma_consts.svh"

interface burst_if;

  // Job request from the sequencer
  logic                    start;
  logic [`ADMA_ADDR_W-1:0] addr;
  logic [`ADMA_LEN_W-1:0]  words;
  logic                    to_desc;

  // Progress back from the mover
  logic                    beat;
  logic [`ADMA_ADDR_W-1:0] data;
  logic                    done;

  modport requester (output start, addr, words, to_desc, input beat, data, done);
  modport mover (input start, addr, words, to_desc, output beat, data, done);

endinterface

`default_nettype wire

// ==== design/adma_pkg.sv ====
`default_nettype none

package adma_pkg;

  // Descriptor sequencer states
  typedef enum logic [1:0] {
    STOP   = 2'b00,
    FETCH  = 2'b01,
    DECODE = 2'b10,
    XFER   = 2'b11
  } adma_state_t;

  // Action field of a descriptor line
  typedef enum logic [1:0] {
    NOP  = 2'b00,
    RSV  = 2'b01,
    TRAN = 2'b10,
    LINK = 2'b11
  } desc_act_t;

  // Burst mover phases
  typedef enum logic [1:0] {
    BS_IDLE = 2'b00,
    BS_WAIT = 2'b01,
    BS_ADDR = 2'b10,
    BS_DATA = 2'b11
  } burst_state_t;

endpackage

`default_nettype wire

// ==== design/adma_consts.svh ====
`ifndef ADMA_CONSTS_SVH
`define ADMA_CONSTS_SVH

// Bus and counter widths
`define ADMA_ADDR_W 32
`define ADMA_LEN_W 17

// Data burst shape
`define ADMA_BURST_WORDS 16
`define ADMA_BURST_BYTES 64

// Descriptor fetch
`define ADMA_DESC_WORDS 2
`define ADMA_DESC_STEP 8

// Descriptor line fields
`define ADMA_DESC_VALID 0
`define ADMA_DESC_END 1
`define ADMA_DESC_ACT_LSB 4
`define ADMA_DESC_LEN_LSB 16
`define ADMA_DESC_ADDR_LSB 32

`endif
